// File: src/puzzle_params.svh
`ifndef PUZZLE_PARAMS_SVH
`define PUZZLE_PARAMS_SVH

// Puzzle geometry
`define PUZZLE_ARG_RANKS 4
`define PUZZLE_MAX_COLS 16

// One number holds up to 9999
`define PUZZLE_ARG_WIDTH 14

// Index widths into the row stores
`define PUZZLE_ROW_WIDTH 2
`define PUZZLE_COL_WIDTH 4

// Four 14-bit factors need 56 bits
`define PUZZLE_PROBLEM_WIDTH 56
`define PUZZLE_TOTAL_WIDTH 64

`define PUZZLE_BYTE_WIDTH 8

`endif

// File: src/puzzle_pkg.sv
`include "puzzle_params.svh"

package puzzle_pkg;

    typedef logic [`PUZZLE_BYTE_WIDTH-1:0] byte_t;
    typedef logic [`PUZZLE_ROW_WIDTH-1:0] arg_row_t;
    typedef logic [`PUZZLE_COL_WIDTH-1:0] arg_col_t;
    typedef logic [`PUZZLE_ARG_WIDTH-1:0] arg_data_t;
    typedef logic [`PUZZLE_PROBLEM_WIDTH-1:0] problem_t;
    typedef logic [`PUZZLE_TOTAL_WIDTH-1:0] total_t;

    // Count of number rows, 0 to PUZZLE_ARG_RANKS
    typedef logic [`PUZZLE_ROW_WIDTH:0] rows_t;

    // One finished number headed for the row stores
    typedef struct packed {
        arg_row_t  row;
        arg_col_t  col;
        arg_data_t data;
    } arg_wr_t;

    // One column to solve; mult high selects product
    typedef struct packed {
        arg_col_t col;
        rows_t    rows;
        logic     mult;
    } solve_req_t;

endpackage

// File: src/tap_decoder.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module tap_decoder (
    input  logic              tck,
    input  logic              rst,
    input  logic              tdi,
    input  logic              ir_is_user,
    input  logic              shift_dr,
    input  logic              update_dr,
    output puzzle_pkg::byte_t byte_data,
    output logic              byte_valid
);

    puzzle_pkg::byte_t shift_reg;

    // TDI enters at the top so the first bit shifted ends up as bit 0
    always_ff @(posedge tck) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (shift_dr && ir_is_user) begin
            shift_reg <= {tdi, shift_reg[`PUZZLE_BYTE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= update_dr && ir_is_user;
        end
    end

    // Byte is held until the next update
    always_ff @(posedge tck) begin
        if (update_dr && ir_is_user) begin
            byte_data <= shift_reg;
        end
    end

endmodule

// File: src/input_decoder.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module input_decoder (
    input  logic                   tck,
    input  logic                   rst,
    input  puzzle_pkg::byte_t      byte_data,
    input  logic                   byte_valid,
    output puzzle_pkg::arg_wr_t    arg_wr,
    output logic                   arg_wr_valid,
    output puzzle_pkg::solve_req_t solve_req,
    output logic                   solve_valid
);

    puzzle_pkg::rows_t     row_cnt;
    puzzle_pkg::arg_col_t  col;
    logic                  col_full;
    puzzle_pkg::arg_data_t acc;
    logic                  digit_seen;
    logic                  op_row;

    logic                  is_digit;
    logic                  is_space;
    logic                  is_newline;
    logic                  is_op;
    logic                  num_end;
    logic                  col_step;
    logic                  pos_ok;
    puzzle_pkg::arg_data_t acc_next;

    always_comb begin
        is_digit   = (byte_data >= 8'h30) && (byte_data <= 8'h39);
        is_space   = (byte_data == 8'h20);
        is_newline = (byte_data == 8'h0a);
        is_op      = (byte_data == 8'h2b) || (byte_data == 8'h2a);
        // Operator row ignores separators
        num_end    = byte_valid && !op_row && (is_space || is_newline);
        col_step   = byte_valid && ((is_space && !op_row) || is_op);
        pos_ok     = (row_cnt < puzzle_pkg::rows_t'(`PUZZLE_ARG_RANKS)) && !col_full;
        // acc * 10 as two shifts, plus the low nibble of the ASCII digit
        acc_next   = (acc << 3) + (acc << 1) + puzzle_pkg::arg_data_t'(byte_data[3:0]);
    end

    // Number accumulation
    always_ff @(posedge tck) begin
        if (rst) begin
            acc        <= '0;
            digit_seen <= 1'b0;
        end else if (byte_valid && is_digit && !op_row) begin
            acc        <= acc_next;
            digit_seen <= 1'b1;
        end else if (num_end) begin
            acc        <= '0;
            digit_seen <= 1'b0;
        end
    end

    // Row and column position
    always_ff @(posedge tck) begin
        if (rst) begin
            row_cnt  <= '0;
            col      <= '0;
            col_full <= 1'b0;
            op_row   <= 1'b0;
        end else begin
            if (num_end && is_newline) begin
                col      <= '0;
                col_full <= 1'b0;
                // Saturates so a fifth row stays out of range
                if (row_cnt < puzzle_pkg::rows_t'(`PUZZLE_ARG_RANKS)) begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else if (col_step) begin
                if (col == puzzle_pkg::arg_col_t'(`PUZZLE_MAX_COLS - 1)) begin
                    col_full <= 1'b1;
                end
                col <= col + 1'b1;
            end
            if (byte_valid && is_op) begin
                op_row <= 1'b1;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            arg_wr_valid <= 1'b0;
            solve_valid  <= 1'b0;
        end else begin
            arg_wr_valid <= num_end && digit_seen && pos_ok;
            solve_valid  <= byte_valid && is_op && !col_full;
        end
    end

    always_ff @(posedge tck) begin
        if (byte_valid) begin
            arg_wr.row     <= row_cnt[`PUZZLE_ROW_WIDTH-1:0];
            arg_wr.col     <= col;
            arg_wr.data    <= acc;
            solve_req.col  <= col;
            solve_req.rows <= row_cnt;
            solve_req.mult <= (byte_data == 8'h2a);
        end
    end

endmodule

// File: src/arg_row_store.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module arg_row_store #(
    parameter int RANK = 0
) (
    input  logic                  tck,
    input  puzzle_pkg::arg_wr_t   arg_wr,
    input  logic                  arg_wr_valid,
    input  puzzle_pkg::arg_col_t  rd_col,
    output puzzle_pkg::arg_data_t rd_data
);

    puzzle_pkg::arg_data_t mem [`PUZZLE_MAX_COLS];

    logic row_match;

    // Writes are broadcast and only this rank's row is kept
    always_comb begin
        row_match = (arg_wr.row == puzzle_pkg::arg_row_t'(RANK));
    end

    always_ff @(posedge tck) begin
        if (arg_wr_valid && row_match) begin
            mem[arg_wr.col] <= arg_wr.data;
        end
    end

    // Registered read, one cycle behind the solve request
    always_ff @(posedge tck) begin
        rd_data <= mem[rd_col];
    end

endmodule

// File: src/column_solver.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module column_solver (
    input  logic                   tck,
    input  logic                   rst,
    input  puzzle_pkg::solve_req_t solve_req,
    input  logic                   solve_valid,
    input  puzzle_pkg::arg_data_t  rd_data [`PUZZLE_ARG_RANKS],
    output puzzle_pkg::total_t     grand_total
);

    puzzle_pkg::solve_req_t req_d;
    logic                   req_valid_d;

    puzzle_pkg::problem_t   operand [`PUZZLE_ARG_RANKS];
    puzzle_pkg::problem_t   col_sum;
    puzzle_pkg::problem_t   col_prod;

    puzzle_pkg::problem_t   problem;
    logic                   problem_valid;

    // Stage one lines the request up with the store read data
    always_ff @(posedge tck) begin
        if (rst) begin
            req_valid_d <= 1'b0;
        end else begin
            req_valid_d <= solve_valid;
        end
    end

    always_ff @(posedge tck) begin
        req_d <= solve_req;
    end

    // Missing ranks become the identity of the selected operation
    always_comb begin
        col_sum  = '0;
        col_prod = puzzle_pkg::problem_t'(1);
        for (int k = 0; k < `PUZZLE_ARG_RANKS; k++) begin
            if (puzzle_pkg::rows_t'(k) < req_d.rows) begin
                operand[k] = puzzle_pkg::problem_t'(rd_data[k]);
            end else if (req_d.mult) begin
                operand[k] = puzzle_pkg::problem_t'(1);
            end else begin
                operand[k] = '0;
            end
            col_sum  = col_sum + operand[k];
            col_prod = col_prod * operand[k];
        end
    end

    // Stage two registers the column result
    always_ff @(posedge tck) begin
        if (rst) begin
            problem_valid <= 1'b0;
        end else begin
            problem_valid <= req_valid_d;
        end
    end

    always_ff @(posedge tck) begin
        problem <= req_d.mult ? col_prod : col_sum;
    end

    // Stage three keeps the running total
    always_ff @(posedge tck) begin
        if (rst) begin
            grand_total <= '0;
        end else if (problem_valid) begin
            grand_total <= grand_total + puzzle_pkg::total_t'(problem);
        end
    end

endmodule

// File: src/tap_encoder.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module tap_encoder (
    input  logic               tck,
    input  logic               rst,
    input  puzzle_pkg::total_t grand_total,
    input  logic               ir_is_user,
    input  logic               capture_dr,
    input  logic               shift_dr,
    output logic               tdo
);

    puzzle_pkg::total_t shift_reg;

    // Capture takes the live total and shifting sends it out LSB first
    always_ff @(posedge tck) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (ir_is_user) begin
            if (capture_dr) begin
                shift_reg <= grand_total;
            end else if (shift_dr) begin
                shift_reg <= {1'b0, shift_reg[`PUZZLE_TOTAL_WIDTH-1:1]};
            end
        end
    end

    assign tdo = shift_reg[0];

endmodule

// File: src/user_logic.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module user_logic (
    input  logic tck,
    input  logic rst,
    input  logic tdi,
    output logic tdo,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr
);

    puzzle_pkg::byte_t      byte_data;
    logic                   byte_valid;

    puzzle_pkg::arg_wr_t    arg_wr;
    logic                   arg_wr_valid;
    puzzle_pkg::solve_req_t solve_req;
    logic                   solve_valid;

    puzzle_pkg::arg_data_t  rd_data [`PUZZLE_ARG_RANKS];
    puzzle_pkg::total_t     grand_total;

    tap_decoder tap_decoder_i (
        .tck        (tck),
        .rst        (rst),
        .tdi        (tdi),
        .ir_is_user (ir_is_user),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    input_decoder input_decoder_i (
        .tck          (tck),
        .rst          (rst),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .arg_wr       (arg_wr),
        .arg_wr_valid (arg_wr_valid),
        .solve_req    (solve_req),
        .solve_valid  (solve_valid)
    );

    // One column memory per number row
    for (genvar r = 0; r < `PUZZLE_ARG_RANKS; r++) begin : gen_rank
        arg_row_store #(
            .RANK (r)
        ) arg_row_store_i (
            .tck          (tck),
            .arg_wr       (arg_wr),
            .arg_wr_valid (arg_wr_valid),
            .rd_col       (solve_req.col),
            .rd_data      (rd_data[r])
        );
    end

    column_solver column_solver_i (
        .tck         (tck),
        .rst         (rst),
        .solve_req   (solve_req),
        .solve_valid (solve_valid),
        .rd_data     (rd_data),
        .grand_total (grand_total)
    );

    tap_encoder tap_encoder_i (
        .tck         (tck),
        .rst         (rst),
        .grand_total (grand_total),
        .ir_is_user  (ir_is_user),
        .capture_dr  (capture_dr),
        .shift_dr    (shift_dr),
        .tdo         (tdo)
    );

endmodule

// File: tests/user_logic_assertions.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module user_logic_assertions (
    input logic               tck,
    input logic               rst,
    input logic               byte_valid,
    input logic               arg_wr_valid,
    input puzzle_pkg::rows_t  row_cnt,
    input logic               solve_valid,
    input logic               problem_valid,
    input puzzle_pkg::total_t grand_total
);

    logic pulse_fail = 1'b0;
    logic row_fail = 1'b0;
    logic total_fail = 1'b0;
    logic reset_fail = 1'b0;
    logic any_fail;

    assign any_fail = pulse_fail || row_fail || total_fail || reset_fail;

    // One byte per update
    assert property (@(posedge tck) disable iff (rst) byte_valid |=> !byte_valid)
        else begin
            $error("byte_valid high for two cycles");
            pulse_fail = 1'b1;
        end

    // Full row count in the decoder when the number ended
    assert property (@(posedge tck) disable iff (rst)
        arg_wr_valid |-> ($past(row_cnt) < puzzle_pkg::rows_t'(`PUZZLE_ARG_RANKS)))
        else begin
            $error("argument write beyond the last row");
            row_fail = 1'b1;
        end

    // Total moves only when a column result lands
    assert property (@(posedge tck) disable iff (rst)
        (grand_total != $past(grand_total)) |-> ($past(problem_valid) || $past(rst)))
        else begin
            $error("grand_total changed without problem_valid");
            total_fail = 1'b1;
        end

    assert property (@(posedge tck)
        rst |=> (!byte_valid && !arg_wr_valid && !solve_valid && !problem_valid))
        else begin
            $error("valid high in the cycle after reset");
            reset_fail = 1'b1;
        end

endmodule

// File: tests/user_logic_tb.sv
`timescale 1ns/1ns
`include "puzzle_params.svh"

module user_logic_tb;

    // Well above the cycles the six tests take
    localparam int max_cycles = 30000;
    localparam int ranks = `PUZZLE_ARG_RANKS;
    localparam int cols = `PUZZLE_MAX_COLS;

    logic tck = 1'b0;
    logic rst;
    logic tdi;
    logic tdo;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    int cycles = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // Reference model of the parser and column solver
    longint unsigned model_store [ranks][cols];
    longint unsigned model_acc;
    longint unsigned model_total;
    int              model_row;
    int              model_col;
    bit              model_seen;
    bit              model_op_row;

    user_logic user_logic_i (.*);

    bind user_logic user_logic_assertions assertions_i (
        .tck           (tck),
        .rst           (rst),
        .byte_valid    (byte_valid),
        .arg_wr_valid  (arg_wr_valid),
        .row_cnt       (input_decoder_i.row_cnt),
        .solve_valid   (solve_valid),
        .problem_valid (column_solver_i.problem_valid),
        .grand_total   (grand_total)
    );

    always #2 tck = ~tck;

    always @(posedge tck) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Run stopped, no result after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (4) @(posedge tck);
        rst <= 1'b0;
        model_acc    = 64'd0;
        model_total  = 64'd0;
        model_row    = 0;
        model_col    = 0;
        model_seen   = 1'b0;
        model_op_row = 1'b0;
    endtask

    // LSB first, then one update pulse
    task automatic jtag_write_byte(input logic [7:0] value, input logic user);
        @(posedge tck);
        ir_is_user <= user;
        shift_dr   <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            tdi <= value[i];
            @(posedge tck);
        end
        shift_dr  <= 1'b0;
        update_dr <= 1'b1;
        @(posedge tck);
        update_dr  <= 1'b0;
        ir_is_user <= 1'b1;
        repeat (6) @(posedge tck);
    endtask

    task automatic jtag_read_total(output logic [63:0] value);
        @(posedge tck);
        ir_is_user <= 1'b1;
        capture_dr <= 1'b1;
        @(posedge tck);
        capture_dr <= 1'b0;
        shift_dr   <= 1'b1;
        // Sampled mid cycle, bit 0 first
        for (int i = 0; i < 64; i++) begin
            @(negedge tck);
            value[i] = tdo;
            @(posedge tck);
        end
        shift_dr <= 1'b0;
    endtask

    task automatic model_byte(input logic [7:0] ch);
        longint unsigned result;
        if (ch >= 8'h30 && ch <= 8'h39) begin
            if (!model_op_row) begin
                model_acc  = model_acc * 64'd10 + 64'(ch - 8'h30);
                model_seen = 1'b1;
            end
        end else if ((ch == 8'h20 || ch == 8'h0a) && !model_op_row) begin
            if (model_seen && model_row < ranks && model_col < cols) begin
                model_store[model_row][model_col] = model_acc;
            end
            model_acc  = 64'd0;
            model_seen = 1'b0;
            if (ch == 8'h20) begin
                model_col++;
            end else begin
                model_col = 0;
                model_row = (model_row < ranks) ? model_row + 1 : model_row;
            end
        end else if (ch == 8'h2b || ch == 8'h2a) begin
            model_op_row = 1'b1;
            if (model_col < cols) begin
                result = (ch == 8'h2a) ? 64'd1 : 64'd0;
                for (int k = 0; k < model_row; k++) begin
                    if (ch == 8'h2a) begin
                        result = result * model_store[k][model_col];
                    end else begin
                        result = result + model_store[k][model_col];
                    end
                end
                model_total = model_total + result;
            end
            model_col++;
        end
    endtask

    task automatic send_puzzle(input string text);
        for (int i = 0; i < text.len(); i++) begin
            model_byte(text[i]);
            jtag_write_byte(text[i], 1'b1);
        end
    endtask

    task automatic run_puzzle(input string text);
        logic [63:0] total;
        apply_reset();
        send_puzzle(text);
        jtag_read_total(total);
        check_value("grand_total", total, model_total);
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d mismatches", tests_run, name, errors - err_start);
        end
    endtask

    initial begin
        logic [63:0] total;
        logic [63:0] held;
        string       text;
        int          err_start;
        void'($urandom(32'h112be5ff));
        rst        <= 1'b1;
        tdi        <= 1'b0;
        ir_is_user <= 1'b0;
        capture_dr <= 1'b0;
        shift_dr   <= 1'b0;
        update_dr  <= 1'b0;
        apply_reset();

        err_start = errors;
        jtag_read_total(total);
        check_value("grand_total", total, 64'd0);
        end_test("total after reset", err_start);

        err_start = errors;
        run_puzzle("12 34 5\n7 8 90\n+ + +\n");
        end_test("two rows of sums", err_start);

        err_start = errors;
        run_puzzle("9999 1\n9999 2\n9999 3\n9999 4\n* +\n");
        end_test("four-factor product and sum", err_start);

        // Three rows of eight random columns
        err_start = errors;
        text = "";
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 8; c++) begin
                text = {text, $sformatf("%0d%s", $urandom_range(9999), (c == 7) ? "\n" : " ")};
            end
        end
        for (int c = 0; c < 8; c++) begin
            text = {text, $sformatf("%s%s", ($urandom_range(1) == 1) ? "*" : "+",
                                    (c == 7) ? "\n" : " ")};
        end
        run_puzzle(text);
        end_test("random columns", err_start);

        // Operator and digit with the user instruction off, then stray bytes
        err_start = errors;
        jtag_read_total(held);
        jtag_write_byte(8'h2a, 1'b0);
        jtag_write_byte(8'h37, 1'b0);
        send_puzzle("#x\t");
        jtag_read_total(total);
        check_value("grand_total", total, held);
        jtag_read_total(total);
        check_value("grand_total", total, held);
        check_value("grand_total", total, model_total);
        end_test("ignored bytes and repeated read", err_start);

        err_start = errors;
        run_puzzle("2 3\n4 5\n6 7\n8 9\n5 5\n* +\n");
        apply_reset();
        jtag_read_total(total);
        check_value("grand_total", total, 64'd0);
        send_puzzle("10 20\n30 40\n* *\n");
        jtag_read_total(total);
        check_value("grand_total", total, model_total);
        end_test("fifth row and new puzzle", err_start);

        $display("Tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && !user_logic_i.assertions_i.any_fail) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
src/puzzle_pkg.sv
src/tap_decoder.sv
src/input_decoder.sv
src/arg_row_store.sv
src/column_solver.sv
src/tap_encoder.sv
src/user_logic.sv
tests/user_logic_assertions.sv
tests/user_logic_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the user_logic testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f tb.f --top-module user_logic_tb -o user_logic_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/user_logic_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1
